/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_simd_noncomp_slice
FILELIST  := simd_noncomp_slice.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv dv/*.sv dv/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^RESULT: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_ref.svh */
// ---------------------------------------------------------------------
// Reference model of the slice and the stimulus LFSR
// Included inside the testbench module, functions only
// FP16 values sit in the low 16 bits of a 32-bit word
// ---------------------------------------------------------------------
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// Total order on numbers, -0 sorts just below +0
function automatic longint order_key(input logic sign, input logic [30:0] mag);
  longint m;
  m = longint'(mag);
  return sign ? (-2 * m - 1) : (2 * m);
endfunction

function automatic logic [31:0] set_sign(input logic [31:0] v, input logic s, input bit is32);
  logic [31:0] r;
  r = v;
  if (is32) r[31] = s;
  else r[15] = s;
  return r;
endfunction

// One lane, nv in bit 32 and the value in the low bits
function automatic logic [32:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                         input fp_fmt_pkg::operation_e op, input bit is32);
  logic [30:0] mag_a, mag_b, inf_mag, quiet_mag;
  logic        sign_a, sign_b, nan_a, nan_b, nv;
  logic [31:0] res, canon;
  if (is32) begin
    sign_a    = a[31];
    sign_b    = b[31];
    mag_a     = a[30:0];
    mag_b     = b[30:0];
    inf_mag   = 31'h7f800000;
    quiet_mag = 31'h7fc00000;             // Smallest quiet NaN
    canon     = 32'h7fc00000;
  end else begin
    sign_a    = a[15];
    sign_b    = b[15];
    mag_a     = {16'b0, a[14:0]};
    mag_b     = {16'b0, b[14:0]};
    inf_mag   = 31'h7c00;
    quiet_mag = 31'h7e00;
    canon     = 32'h7e00;
  end
  nan_a = mag_a > inf_mag;
  nan_b = mag_b > inf_mag;
  nv    = 1'b0;
  res   = a;
  case (op)
    fp_fmt_pkg::FMIN, fp_fmt_pkg::FMAX: begin
      nv = (nan_a && mag_a < quiet_mag) || (nan_b && mag_b < quiet_mag);
      if (nan_a && nan_b) res = canon;
      else if (nan_a) res = b;
      else if (nan_b) res = a;
      else if (op == fp_fmt_pkg::FMIN)
        res = (order_key(sign_a, mag_a) <= order_key(sign_b, mag_b)) ? a : b;
      else
        res = (order_key(sign_a, mag_a) >= order_key(sign_b, mag_b)) ? a : b;
    end
    fp_fmt_pkg::FSGNJ:  res = set_sign(a, sign_b, is32);
    fp_fmt_pkg::FSGNJN: res = set_sign(a, ~sign_b, is32);
    fp_fmt_pkg::FSGNJX: res = set_sign(a, sign_a ^ sign_b, is32);
    default:            res = canon;
  endcase
  return {nv, res};
endfunction

// Whole slice, status under the SIMD mask
function automatic void ref_slice(input logic [31:0] a, input logic [31:0] b,
                                  input fp_fmt_pkg::operation_e op,
                                  input fp_fmt_pkg::fp_format_e fmt, input logic vec,
                                  input logic [1:0] mask, output logic [31:0] res,
                                  output fp_fmt_pkg::status_t st);
  logic [32:0] l0, l1;
  logic [15:0] a16, b16;
  st = '0;
  if (fmt == fp_fmt_pkg::FP32) begin
    l0    = lane_ref(a, b, op, 1'b1);
    res   = l0[31:0];
    st.nv = l0[32] & mask[0];
  end else if (vec) begin
    l0    = lane_ref({16'h0, a[15:0]}, {16'h0, b[15:0]}, op, 1'b0);
    l1    = lane_ref({16'h0, a[31:16]}, {16'h0, b[31:16]}, op, 1'b0);
    res   = {l1[15:0], l0[15:0]};
    st.nv = (l0[32] & mask[0]) | (l1[32] & mask[1]);
  end else begin
    a16   = (a[31:16] == 16'hffff) ? a[15:0] : 16'h7e00;   // Unboxed reads as NaN
    b16   = (b[31:16] == 16'hffff) ? b[15:0] : 16'h7e00;
    l0    = lane_ref({16'h0, a16}, {16'h0, b16}, op, 1'b0);
    res   = {16'hffff, l0[15:0]};
    st.nv = l0[32] & mask[0];
  end
endfunction

`endif

/* dv/tb_simd_noncomp_slice.sv */
// ---------------------------------------------------------------------
// Testbench for the two-lane SIMD min/max and sign injection slice
// Mask is changed only while the slice is empty
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_simd_noncomp_slice;

  localparam int          WAIT_LIMIT = 2000;    // Cycles per wait loop
  localparam logic [31:0] SEED       = 32'h65e1;

  typedef struct packed {
    logic [31:0]         result;
    fp_fmt_pkg::status_t status;
    logic [3:0]          tag;
  } exp_t;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  logic [31:0]            operand_a_i, operand_b_i;
  fp_fmt_pkg::operation_e op_i;
  fp_fmt_pkg::fp_format_e fmt_i;
  logic                   vectorial_op_i;
  logic [1:0]             simd_mask_i;
  logic [3:0]             tag_i;
  logic                   in_valid_i, in_ready_o;
  logic                   out_valid_o, out_ready_i;
  logic [31:0]            result_o;
  fp_fmt_pkg::status_t    status_o;
  logic [3:0]             tag_o;
  logic                   busy_o;

  exp_t        exp_q[$];       // Accepted items, oldest first
  logic [31:0] lfsr_state;
  logic        stall_mode;
  logic [3:0]  next_tag;
  int          cmp_errors, cmp_checks, drv_errors, drv_checks;

  `include "tb_ref.svh"

  simd_noncomp_slice simd_noncomp_slice_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .operand_a_i (operand_a_i), .operand_b_i (operand_b_i),
    .op_i (op_i), .fmt_i (fmt_i), .vectorial_op_i (vectorial_op_i),
    .simd_mask_i (simd_mask_i), .tag_i (tag_i),
    .in_valid_i (in_valid_i), .in_ready_o (in_ready_o),
    .out_valid_o (out_valid_o), .out_ready_i (out_ready_i),
    .result_o (result_o), .status_o (status_o), .tag_o (tag_o), .busy_o (busy_o)
  );

  always #4 clk_i = ~clk_i;

  // ---------------------------------------------------------------------
  // Random stimulus
  // ---------------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Biased toward zeros, infinities and both NaN kinds
  function automatic logic [31:0] rand_fp(input bit is32);
    logic [31:0] sel, sgn, frac, v;
    sel  = rand_bits(3);
    sgn  = rand_bits(1);
    frac = rand_bits(22);
    case (sel[2:0])
      3'd0: v = is32 ? {sgn[0], 31'h0} : {16'h0, sgn[0], 15'h0};
      3'd1: v = is32 ? {sgn[0], 8'hff, 1'b1, frac[21:0]} : {16'h0, sgn[0], 5'h1f, 1'b1, frac[8:0]};
      3'd2: v = is32 ? {sgn[0], 8'hff, 1'b0, frac[21:1], 1'b1}
                     : {16'h0, sgn[0], 5'h1f, 1'b0, frac[8:1], 1'b1};   // Signalling
      3'd3: v = is32 ? {sgn[0], 8'hff, 23'h0} : {16'h0, sgn[0], 5'h1f, 10'h0};
      default: v = is32 ? rand_bits(32) : rand_bits(16);
    endcase
    return v;
  endfunction

  function automatic logic [31:0] rand_vec16();
    logic [31:0] lo, hi;
    lo = rand_fp(1'b0);
    hi = rand_fp(1'b0);
    return {hi[15:0], lo[15:0]};
  endfunction

  // Mostly boxed, sometimes garbage above the value
  function automatic logic [31:0] rand_scalar16();
    logic [31:0] r, v, up;
    r  = rand_bits(2);
    v  = rand_fp(1'b0);
    up = rand_bits(16);
    return (r[1:0] == 2'd0) ? {up[15:0], v[15:0]} : {16'hffff, v[15:0]};
  endfunction

  function automatic fp_fmt_pkg::operation_e rand_op();
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
      3'd0, 3'd5: return fp_fmt_pkg::FMIN;
      3'd1, 3'd6: return fp_fmt_pkg::FMAX;
      3'd2:       return fp_fmt_pkg::FSGNJ;
      3'd3:       return fp_fmt_pkg::FSGNJN;
      default:    return fp_fmt_pkg::FSGNJX;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Driver tasks, each starts and ends on a falling edge
  // ---------------------------------------------------------------------
  task automatic end_run();
    $display("checks %0d, errors %0d", cmp_checks + drv_checks, cmp_errors + drv_errors);
    if (cmp_errors + drv_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic send_item(input logic [31:0] a, input logic [31:0] b,
                           input fp_fmt_pkg::operation_e op, input fp_fmt_pkg::fp_format_e fmt,
                           input logic vec, input exp_t item);
    int   cyc;
    logic done;
    operand_a_i    = a;
    operand_b_i    = b;
    op_i           = op;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    tag_i          = next_tag;
    in_valid_i     = 1'b1;
    item.tag       = next_tag;
    done = 1'b0;
    cyc  = 0;
    while (!done && cyc < WAIT_LIMIT) begin
      #1;
      if (in_ready_o) begin                      // Accepted on the coming edge
        exp_q.push_back(item);
        done = 1'b1;
      end
      @(negedge clk_i);
      cyc++;
    end
    in_valid_i = 1'b0;
    next_tag   = next_tag + 4'd1;
    if (!done) begin
      $display("timeout: item with tag %h was never accepted", item.tag);
      drv_errors++;
    end
  endtask

  task automatic send_ref(input logic [31:0] a, input logic [31:0] b,
                          input fp_fmt_pkg::operation_e op, input fp_fmt_pkg::fp_format_e fmt,
                          input logic vec);
    exp_t                item;
    logic [31:0]         res;
    fp_fmt_pkg::status_t st;
    ref_slice(a, b, op, fmt, vec, simd_mask_i, res, st);
    item.result = res;
    item.status = st;
    item.tag    = '0;
    send_item(a, b, op, fmt, vec, item);
  endtask

  task automatic drain();
    int   cyc;
    logic done;
    done = 1'b0;
    cyc  = 0;
    while (!done && cyc < WAIT_LIMIT) begin
      #3;
      if (exp_q.size() == 0 && !busy_o && !out_valid_o) done = 1'b1;
      @(negedge clk_i);
      cyc++;
    end
    if (!done) begin
      $display("timeout: %0d items still expected at the output", exp_q.size());
      drv_errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int items,
                             input int err_start);
    $display("test %0d %s items %0d errors %0d", num, name, items,
             cmp_errors + drv_errors - err_start);
  endtask

  // ---------------------------------------------------------------------
  // Compare process, samples mid low phase
  // ---------------------------------------------------------------------
  initial begin : compare_outputs
    exp_t                exp_item;
    logic                held;
    logic [31:0]         held_result;
    fp_fmt_pkg::status_t held_status;
    logic [3:0]          held_tag;
    held = 1'b0;
    forever begin
      @(negedge clk_i);
      #2;
      if (rst_n_i) begin
        if (held) begin
          cmp_checks++;
          if (!out_valid_o || result_o !== held_result || status_o !== held_status ||
              tag_o !== held_tag) begin
            $display("output changed while stalled, tag %h", held_tag);
            cmp_errors++;
          end
        end
        if (out_valid_o && out_ready_i) begin
          if (exp_q.size() == 0) begin
            $display("output item with tag %h arrived with none expected", tag_o);
            cmp_errors++;
          end else begin
            exp_item = exp_q.pop_front();
            cmp_checks++;
            if (tag_o !== exp_item.tag) begin
              $display("[FAIL] tag_o exp %h got %h", exp_item.tag, tag_o);
              cmp_errors++;
            end
            if (result_o !== exp_item.result) begin
              $display("[FAIL] result_o exp %h got %h (tag %h)", exp_item.result, result_o,
                       exp_item.tag);
              cmp_errors++;
            end
            if (status_o !== exp_item.status) begin
              $display("[FAIL] status_o exp %h got %h (tag %h)", exp_item.status, status_o,
                       exp_item.tag);
              cmp_errors++;
            end
          end
        end
        held        = out_valid_o && !out_ready_i;
        held_result = result_o;
        held_status = status_o;
        held_tag    = tag_o;
      end
    end
  end

  // Sink back-pressure, own LFSR stream
  initial begin : drive_ready
    logic [31:0] rdy_state;
    rdy_state   = SEED;
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (stall_mode) begin
        rdy_state   = lfsr_next(rdy_state);
        out_ready_i = rdy_state[0];
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin : main_sequence
    int                     err_start, edges;
    logic                   seen;
    logic [31:0]            a, b, r;
    fp_fmt_pkg::operation_e op;
    exp_t                   item;
    lfsr_state = SEED;
    stall_mode = 1'b0;
    next_tag   = '0;
    cmp_errors = 0;
    cmp_checks = 0;
    drv_errors = 0;
    drv_checks = 0;
    rst_n_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fp_fmt_pkg::FMIN;
    fmt_i          = fp_fmt_pkg::FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = 2'b11;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset state and latency
    err_start = 0;
    #1;
    drv_checks++;
    if (out_valid_o !== 1'b0) begin
      $display("[FAIL] out_valid_o exp 0 got %h", out_valid_o);
      drv_errors++;
    end
    if (busy_o !== 1'b0) begin
      $display("[FAIL] busy_o exp 0 got %h", busy_o);
      drv_errors++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("[FAIL] in_ready_o exp 1 got %h", in_ready_o);
      drv_errors++;
    end
    @(negedge clk_i);
    send_ref(32'h3f800000, 32'h40000000, fp_fmt_pkg::FMIN, fp_fmt_pkg::FP32, 1'b0);
    edges = 1;                                 // The accepting edge
    seen  = 1'b0;
    while (!seen && edges < WAIT_LIMIT) begin
      #2;
      if (out_valid_o) begin
        seen = 1'b1;
        if (busy_o !== 1'b1) begin             // Item still in flight
          $display("[FAIL] busy_o exp 1 got %h", busy_o);
          drv_errors++;
        end
      end else begin
        @(negedge clk_i);
        edges++;
      end
    end
    @(negedge clk_i);
    drv_checks++;
    if (!seen) begin
      $display("timeout: out_valid_o never rose after the first item");
      drv_errors++;
    end else if (edges != 2) begin
      $display("[FAIL] out_valid_o latency exp %h got %h", 2, edges);
      drv_errors++;
    end
    drain();
    report_test(1, "reset and latency", 1, err_start);

    // Scalar FP32
    err_start = cmp_errors + drv_errors;
    for (int i = 0; i < 200; i++) begin
      a  = rand_fp(1'b1);
      b  = rand_fp(1'b1);
      op = rand_op();
      r  = rand_bits(1);                       // Vector flag must be ignored
      send_ref(a, b, op, fp_fmt_pkg::FP32, r[0]);
    end
    drain();
    report_test(2, "scalar fp32", 200, err_start);

    // Vector FP16 under each mask
    err_start = cmp_errors + drv_errors;
    for (int m = 1; m < 4; m++) begin
      simd_mask_i = m[1:0];
      for (int i = 0; i < 100; i++) begin
        a  = rand_vec16();
        b  = rand_vec16();
        op = rand_op();
        send_ref(a, b, op, fp_fmt_pkg::FP16, 1'b1);
      end
      drain();
    end
    simd_mask_i = 2'b11;
    report_test(3, "vector fp16 masked", 300, err_start);

    // Scalar FP16 boxing, an unboxed operand reads as quiet NaN
    err_start   = cmp_errors + drv_errors;
    item.status = '0;
    item.tag    = '0;
    item.result = 32'hffff3c00;
    send_item(32'h1234bc00, 32'hffff3c00, fp_fmt_pkg::FMIN, fp_fmt_pkg::FP16, 1'b0, item);
    item.result = 32'hffffc000;
    send_item(32'hffffc000, 32'h00007bff, fp_fmt_pkg::FMAX, fp_fmt_pkg::FP16, 1'b0, item);
    for (int i = 0; i < 100; i++) begin
      a  = rand_scalar16();
      b  = rand_scalar16();
      op = rand_op();
      send_ref(a, b, op, fp_fmt_pkg::FP16, 1'b0);
    end
    drain();
    report_test(4, "scalar fp16 boxing", 102, err_start);

    // Random stalls on both sides
    err_start  = cmp_errors + drv_errors;
    stall_mode = 1'b1;
    for (int i = 0; i < 300; i++) begin
      r = rand_bits(2);
      repeat (r[1:0]) @(negedge clk_i);        // Input gap
      r = rand_bits(2);
      if (r[0]) begin
        a = r[1] ? rand_vec16() : rand_scalar16();
        b = r[1] ? rand_vec16() : rand_scalar16();
      end else begin
        a = rand_fp(1'b1);
        b = rand_fp(1'b1);
      end
      op = rand_op();
      send_ref(a, b, op, r[0] ? fp_fmt_pkg::FP16 : fp_fmt_pkg::FP32, r[1]);
    end
    drain();
    stall_mode = 1'b0;
    @(negedge clk_i);
    report_test(5, "stalls and ordering", 300, err_start);

    end_run();
  end

endmodule

`default_nettype wire

/* hw/fp_fmt_pkg.sv */
// ---------------------------------------------------------------------
// Floating-point format and operation definitions for the slice
// Only binary32 and binary16 are known here
// Status carries all five IEEE flags, the datapath only ever raises nv
// ---------------------------------------------------------------------
`default_nettype none

package fp_fmt_pkg;

  // Supported formats
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // Width in bits of one value of a format
  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP32) ? 32 : 16;
  endfunction

  // Non-computational operations
  typedef enum logic [2:0] {
    FMIN   = 3'd0,
    FMAX   = 3'd1,
    FSGNJ  = 3'd2,
    FSGNJN = 3'd3,
    FSGNJX = 3'd4
  } operation_e;

  // IEEE exception flags
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // Quiet canonical NaNs
  localparam logic [31:0] CANON_NAN32 = 32'h7fc00000;
  localparam logic [15:0] CANON_NAN16 = 16'h7e00;

endpackage

`default_nettype wire

/* hw/lane_if.sv */
// ---------------------------------------------------------------------
// Result bundle from one lane to the result packer
// Valid/ready handshake, the source holds its payload until transfer
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface lane_if;

  logic                              valid;
  logic                              ready;
  logic [slice_cfg_pkg::DATA_W-1:0]  result;
  fp_fmt_pkg::status_t               status;
  slice_cfg_pkg::lane_meta_t         meta;

  // Lane side
  modport src (
    output valid,
    output result,
    output status,
    output meta,
    input  ready
  );

  // Packer side
  modport snk (
    input  valid,
    input  result,
    input  status,
    input  meta,
    output ready
  );

endinterface

`default_nettype wire

/* hw/noncomp_lane.sv */
// ---------------------------------------------------------------------
// One SIMD lane for min/max and sign injection
// Lane 0 handles FP32 and FP16, higher lanes handle FP16 only
// Unboxed inputs are replaced by the canonical NaN before use
// Latency is NUM_PIPE_REGS cycles with elastic valid/ready stages
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module noncomp_lane #(
  parameter int unsigned lane_idx = 0
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [slice_cfg_pkg::DATA_W-1:0] opa_i,
  input  logic [slice_cfg_pkg::DATA_W-1:0] opb_i,
  input  logic [1:0]                       boxed_i,    // {opb, opa}
  input  fp_fmt_pkg::operation_e           op_i,
  input  slice_cfg_pkg::lane_meta_t        meta_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  output logic                             busy_o,
  lane_if.src                              out
);

  localparam int unsigned NP       = slice_cfg_pkg::NUM_PIPE_REGS;
  localparam bit          HAS_FP32 = (lane_idx == 0);

  typedef struct packed {
    logic        sign;
    logic [30:0] mag;
    logic        is_nan;
    logic        is_snan;
  } fp_class_t;

  // Substitute the canonical NaN for a badly boxed operand
  function automatic logic [31:0] unbox(logic [31:0] op, logic boxed, logic is32);
    logic [31:0] val;
    if (is32) begin
      val = boxed ? op : fp_fmt_pkg::CANON_NAN32;
    end else begin
      val = {16'hffff, (boxed ? op[15:0] : fp_fmt_pkg::CANON_NAN16)};
    end
    return val;
  endfunction

  function automatic fp_class_t classify(logic [31:0] val, logic is32);
    fp_class_t c;
    if (is32) begin
      c.sign    = val[31];
      c.mag     = val[30:0];
      c.is_nan  = (&val[30:23]) & (|val[22:0]);
      c.is_snan = c.is_nan & ~val[22];        // Quiet bit clear
    end else begin
      c.sign    = val[15];
      c.mag     = {16'b0, val[14:0]};
      c.is_nan  = (&val[14:10]) & (|val[9:0]);
      c.is_snan = c.is_nan & ~val[9];
    end
    return c;
  endfunction

  // ---------------------------------------------------------------------
  // Operation
  // ---------------------------------------------------------------------
  logic                use_fp32;
  logic [31:0]         val_a, val_b, canon;
  fp_class_t           cls_a, cls_b;
  logic                a_lt_b;
  logic                inj_sign, is_sgnj;
  logic [31:0]         op_result;
  fp_fmt_pkg::status_t op_status;

  assign use_fp32 = HAS_FP32 && (meta_i.fmt == fp_fmt_pkg::FP32);

  assign val_a = unbox(opa_i, boxed_i[0], use_fp32);
  assign val_b = unbox(opb_i, boxed_i[1], use_fp32);
  assign cls_a = classify(val_a, use_fp32);
  assign cls_b = classify(val_b, use_fp32);
  assign canon = use_fp32 ? fp_fmt_pkg::CANON_NAN32 : {16'hffff, fp_fmt_pkg::CANON_NAN16};

  // Sign-magnitude order, -0 sorts below +0
  assign a_lt_b = (cls_a.sign != cls_b.sign) ? cls_a.sign :
                  cls_a.sign ? (cls_a.mag > cls_b.mag) : (cls_a.mag < cls_b.mag);

  always_comb begin : compute
    op_status = '0;
    op_result = val_a;
    inj_sign  = cls_a.sign;
    is_sgnj   = 1'b0;
    case (op_i)
      fp_fmt_pkg::FMIN, fp_fmt_pkg::FMAX: begin
        op_status.nv = cls_a.is_snan | cls_b.is_snan;
        if (cls_a.is_nan && cls_b.is_nan) begin
          op_result = canon;
        end else if (cls_a.is_nan) begin
          op_result = val_b;                      // Number wins over NaN
        end else if (cls_b.is_nan) begin
          op_result = val_a;
        end else if ((op_i == fp_fmt_pkg::FMIN) == a_lt_b) begin
          op_result = val_a;
        end else begin
          op_result = val_b;
        end
      end
      fp_fmt_pkg::FSGNJ: begin
        inj_sign = cls_b.sign;
        is_sgnj  = 1'b1;
      end
      fp_fmt_pkg::FSGNJN: begin
        inj_sign = ~cls_b.sign;
        is_sgnj  = 1'b1;
      end
      fp_fmt_pkg::FSGNJX: begin
        inj_sign = cls_a.sign ^ cls_b.sign;
        is_sgnj  = 1'b1;
      end
      default: begin
        op_result = canon;
      end
    endcase
    if (is_sgnj) begin
      op_result = use_fp32 ? {inj_sign, val_a[30:0]} : {16'hffff, inj_sign, val_a[14:0]};
    end
  end

  // ---------------------------------------------------------------------
  // Elastic pipeline, index i holds the item after i stages
  // ---------------------------------------------------------------------
  logic [NP:0]                        pipe_valid;
  logic [NP:0]                        pipe_ready;
  logic [NP:0][31:0]                  pipe_result;
  fp_fmt_pkg::status_t [NP:0]         pipe_status;
  slice_cfg_pkg::lane_meta_t [NP:0]   pipe_meta;

  assign pipe_valid[0]  = in_valid_i;
  assign pipe_result[0] = op_result;
  assign pipe_status[0] = op_status;
  assign pipe_meta[0]   = meta_i;

  for (genvar i = 0; i < NP; i++) begin : gen_stage
    // Advance when the next stage is empty or drains this cycle
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        pipe_valid[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid[i+1] <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (pipe_ready[i] && pipe_valid[i]) begin
        pipe_result[i+1] <= pipe_result[i];
        pipe_status[i+1] <= pipe_status[i];
        pipe_meta[i+1]   <= pipe_meta[i];
      end
    end
  end

  assign pipe_ready[NP] = out.ready;

  assign in_ready_o = pipe_ready[0];
  assign busy_o     = |pipe_valid[NP:1];   // Any stage occupied

  assign out.valid  = pipe_valid[NP];
  assign out.result = pipe_result[NP];
  assign out.status = pipe_status[NP];
  assign out.meta   = pipe_meta[NP];

  // A stalled result must not change under the packer
  a_hold_result: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      out.valid && !out.ready |=> out.valid && $stable(out.result)
  ) else $error("lane %0d result changed while stalled", lane_idx);

endmodule

`default_nettype wire

/* hw/result_packer.sv */
// ---------------------------------------------------------------------
// Joins the lane results into one output word
// Format and tag come from lane 0, all lanes must move in lockstep
// Status mask is sampled at output time, not carried with the item
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module result_packer (
  lane_if.snk                              lanes [slice_cfg_pkg::NUM_LANES],
  input  logic [slice_cfg_pkg::NUM_LANES-1:0] simd_mask_i,
  input  logic                             out_ready_i,
  output logic                             out_valid_o,
  output logic [slice_cfg_pkg::DATA_W-1:0] result_o,
  output fp_fmt_pkg::status_t              status_o,
  output logic [slice_cfg_pkg::TAG_W-1:0]  tag_o
);

  localparam int unsigned NL     = slice_cfg_pkg::NUM_LANES;
  localparam int unsigned FP16_W = fp_fmt_pkg::fp_width(fp_fmt_pkg::FP16);

  logic [NL-1:0]                            lane_valid;
  logic [NL-1:0][slice_cfg_pkg::DATA_W-1:0] lane_result;
  fp_fmt_pkg::status_t [NL-1:0]             lane_status;
  logic [NL-1:0]                            lane_used;
  slice_cfg_pkg::lane_meta_t                head_meta;

  // ---------------------------------------------------------------------
  // Gather lanes
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < NL; i++) begin : gen_gather
    assign lane_valid[i]  = lanes[i].valid;
    assign lane_result[i] = lanes[i].result;
    assign lane_status[i] = lanes[i].status;
    assign lane_used[i]   = lanes[i].meta.lane_used;
    assign lanes[i].ready = out_ready_i;       // Same ready for every lane
  end

  assign head_meta = lanes[0].meta;

  // ---------------------------------------------------------------------
  // Packing
  // ---------------------------------------------------------------------
  always_comb begin : pack
    result_o = '1;                              // NaN-box unused slots
    if (head_meta.fmt == fp_fmt_pkg::FP32) begin
      result_o = lane_result[0];
    end else begin
      for (int i = 0; i < NL; i++) begin
        if ((i == 0) || head_meta.vectorial) begin
          result_o[i*FP16_W +: FP16_W] = lane_result[i][FP16_W-1:0];
        end
      end
    end
  end

  // Only used and enabled lanes raise flags
  always_comb begin : collapse_status
    status_o = '0;
    for (int i = 0; i < NL; i++) begin
      if (lane_used[i] && simd_mask_i[i]) begin
        status_o = status_o | lane_status[i];
      end
    end
  end

  assign out_valid_o = lane_valid[0];
  assign tag_o       = head_meta.tag;

  // Lanes accept every item together, so they must present together
  always_comb begin : check_lockstep
    a_valid_lockstep: assert final ((&lane_valid) || !(|lane_valid))
      else $error("lane valid signals differ: %b", lane_valid);
  end

endmodule

`default_nettype wire

/* hw/simd_noncomp_slice.sv */
// ---------------------------------------------------------------------
// Two-lane SIMD slice for FP min/max and sign injection
// Vector mode exists for FP16 only, a vector flag with FP32 is ignored
// simd_mask_i must be stable while its item is on the output
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module simd_noncomp_slice (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [slice_cfg_pkg::DATA_W-1:0] operand_a_i,
  input  logic [slice_cfg_pkg::DATA_W-1:0] operand_b_i,
  input  fp_fmt_pkg::operation_e           op_i,
  input  fp_fmt_pkg::fp_format_e           fmt_i,
  input  logic                             vectorial_op_i,
  input  logic [slice_cfg_pkg::NUM_LANES-1:0] simd_mask_i,
  input  logic [slice_cfg_pkg::TAG_W-1:0]  tag_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic [slice_cfg_pkg::DATA_W-1:0] result_o,
  output fp_fmt_pkg::status_t              status_o,
  output logic [slice_cfg_pkg::TAG_W-1:0]  tag_o,
  output logic                             busy_o
);

  localparam int unsigned NL = slice_cfg_pkg::NUM_LANES;
  localparam int unsigned DW = slice_cfg_pkg::DATA_W;
  localparam int unsigned LW = slice_cfg_pkg::LANE_W;

  logic          fp16_op;
  logic          vector_op;
  logic          scalar_fp16;
  logic [1:0]    boxed;          // {opb, opa}
  logic [NL-1:0] lane_in_ready;
  logic [NL-1:0] lane_busy;

  lane_if lane_bus [NL] ();

  // ---------------------------------------------------------------------
  // Input decode
  // ---------------------------------------------------------------------
  assign fp16_op     = (fmt_i == fp_fmt_pkg::FP16);
  assign vector_op   = vectorial_op_i & fp16_op;
  assign scalar_fp16 = fp16_op & ~vectorial_op_i;

  // Scalar FP16 needs all ones above the value
  assign boxed[0] = ~scalar_fp16 | (&operand_a_i[DW-1:LW]);
  assign boxed[1] = ~scalar_fp16 | (&operand_b_i[DW-1:LW]);

  for (genvar g = 0; g < NL; g++) begin : gen_lanes
    logic [DW-1:0]             lane_opa;
    logic [DW-1:0]             lane_opb;
    slice_cfg_pkg::lane_meta_t lane_meta;

    assign lane_opa = operand_a_i >> (g * LW);   // Lane slot at the bottom
    assign lane_opb = operand_b_i >> (g * LW);

    assign lane_meta.fmt       = fmt_i;
    assign lane_meta.vectorial = vector_op;
    assign lane_meta.lane_used = (g == 0) || vector_op;
    assign lane_meta.tag       = tag_i;

    noncomp_lane #(
      .lane_idx (g)
    ) u_lane (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .opa_i      (lane_opa),
      .opb_i      (lane_opb),
      .boxed_i    (boxed),
      .op_i       (op_i),
      .meta_i     (lane_meta),
      .in_valid_i (in_valid_i),           // Every lane takes every item
      .in_ready_o (lane_in_ready[g]),
      .busy_o     (lane_busy[g]),
      .out        (lane_bus[g])
    );
  end

  assign in_ready_o = lane_in_ready[0];
  assign busy_o     = |lane_busy;

  // ---------------------------------------------------------------------
  // Output side
  // ---------------------------------------------------------------------
  result_packer u_packer (
    .lanes       (lane_bus),
    .simd_mask_i (simd_mask_i),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o)
  );

  // Lane 0 speaks for all lanes on the input side
  a_ready_lockstep: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      lane_in_ready == {NL{lane_in_ready[0]}}
  ) else $error("lane ready signals differ: %b", lane_in_ready);

endmodule

`default_nettype wire

/* hw/slice_cfg_pkg.sv */
// ---------------------------------------------------------------------
// Structural configuration of the SIMD slice
// DATA_W must divide evenly into NUM_LANES binary16 slots
// ---------------------------------------------------------------------
`default_nettype none

package slice_cfg_pkg;

  localparam int unsigned DATA_W        = 32;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned LANE_W        = DATA_W / NUM_LANES;  // One FP16 slot
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_W         = 4;

  // Side data that travels with every item through a lane
  typedef struct packed {
    fp_fmt_pkg::fp_format_e fmt;        // Result format
    logic                   vectorial;  // Vector FP16 op
    logic                   lane_used;  // Lane holds a real element
    logic [TAG_W-1:0]       tag;
  } lane_meta_t;

endpackage

`default_nettype wire

/* simd_noncomp_slice.f */
+incdir+dv
hw/fp_fmt_pkg.sv
hw/slice_cfg_pkg.sv
hw/lane_if.sv
hw/noncomp_lane.sv
hw/result_packer.sv
hw/simd_noncomp_slice.sv
dv/tb_simd_noncomp_slice.sv
